//--- gpio_unit.sv
/* GPIO register block with direction, output, synchronized input and
   rising-edge interrupts; accessed through the demultiplexer strobe. */

`timescale 1ns/1ps

module gpio_unit #(
  parameter int unsigned GpioCount = 16
) (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 req_i,
  input  logic                 we_i,
  input  logic [7:0]           offset_i,
  input  periph_pkg::be_t      be_i,
  input  periph_pkg::data_t    wdata_i,
  output periph_pkg::data_t    rdata_o,
  input  logic [GpioCount-1:0] gpio_i,
  output logic [GpioCount-1:0] gpio_o,
  output logic [GpioCount-1:0] gpio_out_en_o,
  output logic                 irq_o
);
  import periph_pkg::*;

  logic [GpioCount-1:0] dir_q;
  logic [GpioCount-1:0] out_q;
  logic [GpioCount-1:0] irq_en_q;
  logic [GpioCount-1:0] status_q;
  logic [GpioCount-1:0] sync1_q;
  logic [GpioCount-1:0] sync2_q;
  logic [GpioCount-1:0] prev_q;
  logic [GpioCount-1:0] rise;
  logic [GpioCount-1:0] clr;
  logic [GpioCount-1:0] mask;
  logic [GpioCount-1:0] wbits;
  data_t                rdata_d;
  data_t                rdata_q;
  logic                 wr;

  assign wr    = req_i && we_i;
  assign mask  = GpioCount'(be_mask(be_i));
  assign wbits = wdata_i[GpioCount-1:0];

  // Enabled rising edges seen after the synchronizer
  assign rise = sync2_q & ~prev_q & irq_en_q;
  assign clr  = (wr && offset_i == GPIO_IRQ_STATUS) ? (wbits & mask) : '0;

  // --------------------
  // Registers
  // --------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      dir_q    <= '0;
      out_q    <= '0;
      irq_en_q <= '0;
      status_q <= '0;
      sync1_q  <= '0;
      sync2_q  <= '0;
      prev_q   <= '0;
    end else begin
      sync1_q <= gpio_i;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
      // A new edge wins over a clear in the same cycle
      status_q <= (status_q & ~clr) | rise;
      if (wr) begin
        case (offset_i)
          GPIO_DIR:    dir_q    <= (dir_q & ~mask) | (wbits & mask);
          GPIO_OUT:    out_q    <= (out_q & ~mask) | (wbits & mask);
          GPIO_IRQ_EN: irq_en_q <= (irq_en_q & ~mask) | (wbits & mask);
          default:     ;
        endcase
      end
    end
  end

  // --------------------
  // Read path
  // --------------------
  always_comb begin
    rdata_d = '0;
    case (offset_i)
      GPIO_DIR:        rdata_d[GpioCount-1:0] = dir_q;
      GPIO_OUT:        rdata_d[GpioCount-1:0] = out_q;
      GPIO_IN:         rdata_d[GpioCount-1:0] = sync2_q;
      GPIO_IRQ_EN:     rdata_d[GpioCount-1:0] = irq_en_q;
      GPIO_IRQ_STATUS: rdata_d[GpioCount-1:0] = status_q;
      default:         ;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rdata_q <= '0;
    end else if (req_i && !we_i) begin
      rdata_q <= rdata_d;
    end
  end

  assign rdata_o       = rdata_q;
  assign gpio_o        = out_q;
  assign gpio_out_en_o = dir_q;
  assign irq_o         = |status_q;

endmodule

//--- periph_demux.sv
/* Peripheral demultiplexer: decodes the region of each request, strobes one unit
   and merges the unit read data, or the error pattern, into a single response. */

`timescale 1ns/1ps

module periph_demux (
  input  logic               clk_i,
  input  logic               rst_i,

  // Subordinate port
  input  logic               req_i,
  input  logic               we_i,
  input  periph_pkg::addr_t  addr_i,
  input  periph_pkg::be_t    be_i,
  input  periph_pkg::data_t  wdata_i,
  output logic               gnt_o,
  output logic               rvalid_o,
  output periph_pkg::data_t  rdata_o,
  output logic               err_o,

  // Unit side
  output logic               gpio_req_o,
  output logic               timer_req_o,
  output logic               we_o,
  output logic [7:0]         offset_o,
  output periph_pkg::be_t    be_o,
  output periph_pkg::data_t  wdata_o,
  input  periph_pkg::data_t  gpio_rdata_i,
  input  periph_pkg::data_t  timer_rdata_i
);
  import periph_pkg::*;

  logic [REGION_W-1:0] region;
  periph_sel_e         sel_d;
  periph_sel_e         sel_q;
  logic                rvalid_q;
  logic                we_q;

  // --------------------
  // Request routing
  // --------------------
  assign region = addr_i[REGION_LSB +: REGION_W];

  always_comb begin
    case (region)
      REGION_GPIO:  sel_d = SEL_GPIO;
      REGION_TIMER: sel_d = SEL_TIMER;
      default:      sel_d = SEL_ERR;
    endcase
  end

  // Units never stall, every request is granted at once
  assign gnt_o = req_i;

  assign gpio_req_o  = req_i && (sel_d == SEL_GPIO);
  assign timer_req_o = req_i && (sel_d == SEL_TIMER);
  assign we_o        = we_i;
  assign offset_o    = addr_i[REGION_LSB-1:0];
  assign be_o        = be_i;
  assign wdata_o     = wdata_i;

  // --------------------
  // Response path
  // --------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rvalid_q <= 1'b0;
      sel_q    <= SEL_GPIO;
      we_q     <= 1'b0;
    end else begin
      rvalid_q <= req_i;
      if (req_i) begin
        sel_q <= sel_d;
        we_q  <= we_i;
      end
    end
  end

  assign rvalid_o = rvalid_q;
  assign err_o    = rvalid_q && (sel_q == SEL_ERR);

  // Writes answer with zero data
  always_comb begin
    rdata_o = '0;
    if (!we_q) begin
      case (sel_q)
        SEL_GPIO:  rdata_o = gpio_rdata_i;
        SEL_TIMER: rdata_o = timer_rdata_i;
        default:   rdata_o = ERR_RDATA;
      endcase
    end
  end

endmodule

//--- periph_domain.sv
/* Peripheral domain top level: one OBI-style subordinate port feeding the
   demultiplexer, the GPIO and timer units, and the combined interrupt vector. */

`timescale 1ns/1ps

module periph_domain #(
  parameter int unsigned GpioCount = 16
) (
  input  logic                             clk_i,
  input  logic                             rst_i,

  input  logic                             req_i,
  input  logic                             we_i,
  input  periph_pkg::addr_t                addr_i,
  input  periph_pkg::be_t                  be_i,
  input  periph_pkg::data_t                wdata_i,
  output logic                             gnt_o,
  output logic                             rvalid_o,
  output periph_pkg::data_t                rdata_o,
  output logic                             err_o,

  input  logic [GpioCount-1:0]             gpio_i,
  output logic [GpioCount-1:0]             gpio_o,
  output logic [GpioCount-1:0]             gpio_out_en_o,

  output logic [periph_pkg::NUM_IRQ-1:0]   irq_o
);
  import periph_pkg::*;

  logic       gpio_req;
  logic       timer_req;
  logic       unit_we;
  logic [7:0] unit_offset;
  be_t        unit_be;
  data_t      unit_wdata;
  data_t      gpio_rdata;
  data_t      timer_rdata;
  logic       gpio_irq;
  logic       timer_irq;

  // Bit 0 timer, bit 1 GPIO
  assign irq_o = {gpio_irq, timer_irq};

  // --------------------
  // Bus demultiplexer
  // --------------------
  periph_demux i_demux (
    .clk_i,
    .rst_i,
    .req_i,
    .we_i,
    .addr_i,
    .be_i,
    .wdata_i,
    .gnt_o,
    .rvalid_o,
    .rdata_o,
    .err_o,
    .gpio_req_o    ( gpio_req    ),
    .timer_req_o   ( timer_req   ),
    .we_o          ( unit_we     ),
    .offset_o      ( unit_offset ),
    .be_o          ( unit_be     ),
    .wdata_o       ( unit_wdata  ),
    .gpio_rdata_i  ( gpio_rdata  ),
    .timer_rdata_i ( timer_rdata )
  );

  // --------------------
  // Peripherals
  // --------------------
  gpio_unit #(
    .GpioCount ( GpioCount )
  ) i_gpio (
    .clk_i,
    .rst_i,
    .req_i     ( gpio_req    ),
    .we_i      ( unit_we     ),
    .offset_i  ( unit_offset ),
    .be_i      ( unit_be     ),
    .wdata_i   ( unit_wdata  ),
    .rdata_o   ( gpio_rdata  ),
    .gpio_i,
    .gpio_o,
    .gpio_out_en_o,
    .irq_o     ( gpio_irq    )
  );

  timer_unit i_timer (
    .clk_i,
    .rst_i,
    .req_i    ( timer_req   ),
    .we_i     ( unit_we     ),
    .offset_i ( unit_offset ),
    .be_i     ( unit_be     ),
    .wdata_i  ( unit_wdata  ),
    .rdata_o  ( timer_rdata ),
    .irq_o    ( timer_irq   )
  );

endmodule

//--- periph_domain_checker.sv
/* Concurrent protocol and reset checks for the peripheral domain,
   bound into periph_domain from the testbench side. */

`timescale 1ns/1ps

module periph_domain_checker #(
  parameter int unsigned GpioCount = 16
) (
  input logic                           clk_i,
  input logic                           rst_i,
  input logic                           req_i,
  input periph_pkg::addr_t              addr_i,
  input logic                           gnt_i,
  input logic                           rvalid_i,
  input logic                           err_i,
  input logic [periph_pkg::NUM_IRQ-1:0] irq_i,
  input logic [GpioCount-1:0]           gpio_out_en_i
);
  import periph_pkg::*;

  int unsigned fail_count = 0;
  logic        mapped;

  assign mapped = addr_i[REGION_LSB +: REGION_W] inside {REGION_GPIO, REGION_TIMER};

  // Quiet outputs in the first cycle after reset
  reset_idle: assert property (@(posedge clk_i)
    $fell(rst_i) |-> !rvalid_i && irq_i == '0 && gpio_out_en_i == '0)
    else begin
      fail_count++;
      $error("outputs not idle after reset");
    end

  grant_now: assert property (@(posedge clk_i) disable iff (rst_i) req_i |-> gnt_i)
    else begin
      fail_count++;
      $error("request not granted in its cycle");
    end

  // One response exactly one cycle after each acceptance
  resp_follows: assert property (@(posedge clk_i) disable iff (rst_i)
    req_i && gnt_i |=> rvalid_i)
    else begin
      fail_count++;
      $error("missing response after acceptance");
    end

  no_stray_resp: assert property (@(posedge clk_i) disable iff (rst_i)
    rvalid_i |-> $past(req_i && gnt_i))
    else begin
      fail_count++;
      $error("response without an accepted request");
    end

  mapped_no_err: assert property (@(posedge clk_i) disable iff (rst_i)
    req_i && gnt_i && mapped |=> !err_i)
    else begin
      fail_count++;
      $error("error flagged on a mapped access");
    end

  unmapped_err: assert property (@(posedge clk_i) disable iff (rst_i)
    req_i && gnt_i && !mapped |=> err_i)
    else begin
      fail_count++;
      $error("unmapped access without error");
    end

endmodule

bind periph_domain periph_domain_checker #(
  .GpioCount ( GpioCount )
) i_checker (
  .clk_i,
  .rst_i,
  .req_i,
  .addr_i,
  .gnt_i         ( gnt_o         ),
  .rvalid_i      ( rvalid_o      ),
  .err_i         ( err_o         ),
  .irq_i         ( irq_o         ),
  .gpio_out_en_i ( gpio_out_en_o )
);

//--- periph_pkg.sv
/* Shared widths, types and address map of the peripheral domain.
   Imported by the demultiplexer, the register units and the top level. */

package periph_pkg;

  // --------------------
  // Bus widths and types
  // --------------------
  localparam int unsigned ADDR_W = 12;
  localparam int unsigned DATA_W = 32;

  typedef logic [ADDR_W-1:0]   addr_t;
  typedef logic [DATA_W-1:0]   data_t;
  typedef logic [DATA_W/8-1:0] be_t;

  // --------------------
  // Address map
  // --------------------
  // Region field sits right above the 256 byte register window
  localparam int unsigned REGION_LSB = 8;
  localparam int unsigned REGION_W   = ADDR_W - REGION_LSB;

  localparam logic [REGION_W-1:0] REGION_GPIO  = 4'd0;
  localparam logic [REGION_W-1:0] REGION_TIMER = 4'd1;

  // Read data returned for unmapped regions
  localparam data_t ERR_RDATA = 32'hBADCAB1E;

  // Target of an accepted request, kept for the response cycle
  typedef enum logic [1:0] {
    SEL_GPIO,
    SEL_TIMER,
    SEL_ERR
  } periph_sel_e;

  // GPIO register offsets
  localparam logic [7:0] GPIO_DIR        = 8'h00;
  localparam logic [7:0] GPIO_OUT        = 8'h04;
  localparam logic [7:0] GPIO_IN         = 8'h08;
  localparam logic [7:0] GPIO_IRQ_EN     = 8'h0C;
  localparam logic [7:0] GPIO_IRQ_STATUS = 8'h10;

  // Timer register offsets
  localparam logic [7:0] TIMER_CTRL   = 8'h00;
  localparam logic [7:0] TIMER_COUNT  = 8'h04;
  localparam logic [7:0] TIMER_CMP    = 8'h08;
  localparam logic [7:0] TIMER_STATUS = 8'h0C;

  // Bit 0 timer, bit 1 GPIO
  localparam int unsigned NUM_IRQ = 2;

  // Expand byte enables into a bit mask over the data word
  function automatic data_t be_mask(be_t be);
    data_t mask;
    for (int i = 0; i < DATA_W / 8; i++) begin
      mask[8*i +: 8] = {8{be[i]}};
    end
    return mask;
  endfunction

endpackage

//--- run_sim.sh
#!/bin/sh
# Build and run the peripheral domain testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_periph_domain -f sim.f -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

# Keep running past assertion errors so the testbench prints its verdict
output=$(./obj_dir/Vtb_periph_domain +verilator+error+limit+1000)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "Result: PASSED"; then
  exit 0
fi
exit 1

//--- sim.f
periph_pkg.sv
periph_demux.sv
gpio_unit.sv
timer_unit.sv
periph_domain.sv
periph_domain_checker.sv
tb_periph_domain.sv

//--- tb_periph_domain.sv
/* Directed testbench for the peripheral domain: drives the OBI-style port,
   checks register readback, error responses and both interrupt paths. */

`timescale 1ns/1ps

module tb_periph_domain;
  import periph_pkg::*;

  localparam int unsigned GPIO_COUNT      = 16;
  localparam int unsigned SEED            = 32'hdd9f_c15f;
  // All tests together take well under 200 cycles
  localparam int unsigned TIMEOUT_CYCLES  = 2000;
  localparam int unsigned HANDSHAKE_LIMIT = 8;
  localparam data_t       ERR_PATTERN     = 32'hBADCAB1E;
  localparam data_t       GPIO_MASK       = data_t'((64'd1 << GPIO_COUNT) - 64'd1);

  logic                        clk_i;
  logic                        rst_i;
  logic                        req_i;
  logic                        we_i;
  addr_t                       addr_i;
  be_t                         be_i;
  data_t                       wdata_i;
  logic                        gnt_o;
  logic                        rvalid_o;
  data_t                       rdata_o;
  logic                        err_o;
  logic [GPIO_COUNT-1:0]       gpio_i;
  logic [GPIO_COUNT-1:0]       gpio_o;
  logic [GPIO_COUNT-1:0]       gpio_out_en_o;
  logic [NUM_IRQ-1:0]          irq_o;
  int unsigned                 errors;

  periph_domain #(
    .GpioCount ( GPIO_COUNT )
  ) i_dut (
    .clk_i,
    .rst_i,
    .req_i,
    .we_i,
    .addr_i,
    .be_i,
    .wdata_i,
    .gnt_o,
    .rvalid_o,
    .rdata_o,
    .err_o,
    .gpio_i,
    .gpio_o,
    .gpio_out_en_o,
    .irq_o
  );

  always #20 clk_i = ~clk_i;

  // --------------------
  // Checks and bus tasks
  // --------------------
  task automatic report_failure(input string msg);
    $display("Error: %s", msg);
    errors++;
  endtask

  task automatic check_word(input string name, input data_t got, input data_t exp);
    assert (got === exp) else begin
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  // Called right after a falling edge, returns on the falling edge of the response
  task automatic access_bus(input logic we, input addr_t addr, input data_t wdata,
                            output data_t rdata, output logic err);
    int waited;
    req_i   = 1'b1;
    we_i    = we;
    addr_i  = addr;
    be_i    = 4'hF;
    wdata_i = wdata;
    waited  = 0;
    @(posedge clk_i);
    while (!gnt_o && waited < HANDSHAKE_LIMIT) begin
      @(posedge clk_i);
      waited++;
    end
    assert (gnt_o) else report_failure("request was never granted");
    @(negedge clk_i);
    req_i  = 1'b0;
    waited = 0;
    while (!rvalid_o && waited < HANDSHAKE_LIMIT) begin
      @(negedge clk_i);
      waited++;
    end
    assert (rvalid_o) else report_failure("no response after an accepted request");
    rdata = rdata_o;
    err   = err_o;
  endtask

  task automatic write_reg(input addr_t addr, input data_t wdata);
    data_t rd;
    logic  er;
    access_bus(1'b1, addr, wdata, rd, er);
    check_word("rdata_o on write", rd, '0);
  endtask

  task automatic read_reg(input addr_t addr, output data_t rdata, output logic err);
    access_bus(1'b0, addr, '0, rdata, err);
  endtask

  // --------------------
  // Stimulus
  // --------------------
  initial begin
    data_t       rd;
    logic        er;
    data_t       out_val;
    data_t       dir_val;
    int          cycles;
    clk_i   = 1'b0;
    rst_i   = 1'b1;
    req_i   = 1'b0;
    we_i    = 1'b0;
    addr_i  = '0;
    be_i    = '0;
    wdata_i = '0;
    gpio_i  = '0;
    errors  = 0;
    void'($urandom(SEED));
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    @(negedge clk_i);

    // GPIO output and direction readback, back to back
    out_val = $urandom();
    dir_val = $urandom();
    write_reg({REGION_GPIO, GPIO_OUT}, out_val);
    write_reg({REGION_GPIO, GPIO_DIR}, dir_val);
    read_reg({REGION_GPIO, GPIO_OUT}, rd, er);
    check_word("rdata_o GPIO_OUT", rd, out_val & GPIO_MASK);
    read_reg({REGION_GPIO, GPIO_DIR}, rd, er);
    check_word("rdata_o GPIO_DIR", rd, dir_val & GPIO_MASK);
    check_word("gpio_o", data_t'(gpio_o), out_val & GPIO_MASK);
    check_word("gpio_out_en_o", data_t'(gpio_out_en_o), dir_val & GPIO_MASK);

    // Unmapped region 5
    read_reg({4'd5, 8'h00}, rd, er);
    check_word("rdata_o unmapped", rd, ERR_PATTERN);
    check_word("err_o", data_t'(er), 32'd1);

    // GPIO edge interrupt on bit 3
    write_reg({REGION_GPIO, GPIO_IRQ_EN}, 32'h8);
    gpio_i[3] = 1'b1;
    cycles    = 0;
    while (!irq_o[1] && cycles < 4) begin
      @(negedge clk_i);
      cycles++;
    end
    assert (irq_o[1]) else report_failure("GPIO interrupt did not rise within 4 cycles");
    read_reg({REGION_GPIO, GPIO_IRQ_STATUS}, rd, er);
    check_word("rdata_o GPIO_IRQ_STATUS", rd, 32'h8);
    write_reg({REGION_GPIO, GPIO_IRQ_STATUS}, 32'h8);
    check_word("irq_o[1]", data_t'(irq_o[1]), 32'd0);
    read_reg({REGION_GPIO, GPIO_IRQ_STATUS}, rd, er);
    check_word("rdata_o GPIO_IRQ_STATUS", rd, 32'h0);

    // Timer compare match, counted from the enabling write
    write_reg({REGION_TIMER, TIMER_CMP}, 32'd10);
    write_reg({REGION_TIMER, TIMER_CTRL}, 32'd1);
    cycles = 0;
    while (!irq_o[0] && cycles < 30) begin
      @(negedge clk_i);
      cycles++;
    end
    check_word("timer irq_o[0] delay", data_t'(cycles), 32'd11);
    write_reg({REGION_TIMER, TIMER_STATUS}, 32'd1);
    check_word("irq_o[0]", data_t'(irq_o[0]), 32'd0);
    write_reg({REGION_TIMER, TIMER_CTRL}, 32'd0);

    repeat (2) @(negedge clk_i);
    $display("Errors: %0d data checks, %0d assertions", errors, i_dut.i_checker.fail_count);
    if (errors == 0 && i_dut.i_checker.fail_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk_i);
    $display("Error: run timed out after %0d cycles", TIMEOUT_CYCLES);
    $display("Result: FAILED");
    $finish;
  end

endmodule

//--- timer_unit.sv
/* Free-running timer with a software-writable counter, a compare register
   and a sticky match interrupt cleared by writing one. */

`timescale 1ns/1ps

module timer_unit (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              req_i,
  input  logic              we_i,
  input  logic [7:0]        offset_i,
  input  periph_pkg::be_t   be_i,
  input  periph_pkg::data_t wdata_i,
  output periph_pkg::data_t rdata_o,
  output logic              irq_o
);
  import periph_pkg::*;

  logic  enable_q;
  data_t count_q;
  data_t cmp_q;
  logic  status_q;
  data_t mask;
  data_t rdata_d;
  data_t rdata_q;
  logic  wr;
  logic  match;
  logic  clr;

  assign wr    = req_i && we_i;
  assign mask  = be_mask(be_i);
  assign match = enable_q && (count_q == cmp_q);
  assign clr   = wr && (offset_i == TIMER_STATUS) && wdata_i[0] && be_i[0];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      enable_q <= 1'b0;
      count_q  <= '0;
      cmp_q    <= '0;
      status_q <= 1'b0;
    end else begin
      // Match sets the flag even when software clears it in the same cycle
      status_q <= (status_q && !clr) || match;

      // Bus write to the counter beats the increment
      if (wr && offset_i == TIMER_COUNT) begin
        count_q <= (count_q & ~mask) | (wdata_i & mask);
      end else if (match) begin
        count_q <= '0;
      end else if (enable_q) begin
        count_q <= count_q + 1'b1;
      end

      if (wr && offset_i == TIMER_CTRL && be_i[0]) begin
        enable_q <= wdata_i[0];
      end
      if (wr && offset_i == TIMER_CMP) begin
        cmp_q <= (cmp_q & ~mask) | (wdata_i & mask);
      end
    end
  end

  // --------------------
  // Read path
  // --------------------
  always_comb begin
    rdata_d = '0;
    case (offset_i)
      TIMER_CTRL:   rdata_d[0] = enable_q;
      TIMER_COUNT:  rdata_d    = count_q;
      TIMER_CMP:    rdata_d    = cmp_q;
      TIMER_STATUS: rdata_d[0] = status_q;
      default:      ;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rdata_q <= '0;
    end else if (req_i && !we_i) begin
      rdata_q <= rdata_d;
    end
  end

  assign rdata_o = rdata_q;
  assign irq_o   = status_q;

endmodule
